//--- verilog/karatsuba_pkg.sv
`default_nettype none

package karatsuba_pkg;

    ////////////////////
    // Sizes

    localparam int LIMB_WIDTH = 16;
    localparam int LIMB_COUNT = 16;

    localparam int OPERAND_WIDTH = LIMB_WIDTH * LIMB_COUNT;
    localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;
    localparam int PAIR_COUNT    = LIMB_COUNT * (LIMB_COUNT - 1) / 2;
    localparam int COLUMN_COUNT  = 2 * LIMB_COUNT - 1;

    // Signed limb difference and its square-sized product
    localparam int DIFF_WIDTH = LIMB_WIDTH + 1;
    localparam int DIAG_WIDTH = 2 * LIMB_WIDTH;
    localparam int MIX_WIDTH  = 2 * DIFF_WIDTH;

    // Widest column holds 16 limb products
    localparam int COLUMN_WIDTH = DIAG_WIDTH + 5;
    // Keep above COLUMN_WIDTH so packed columns never touch
    localparam int ROW_STRIDE   = 3 * LIMB_WIDTH;

    ////////////////////
    // Stage payloads

    typedef struct packed {
        logic                                         valid;
        logic [LIMB_COUNT-1:0][DIAG_WIDTH-1:0]        diag;
        logic [PAIR_COUNT-1:0][DIFF_WIDTH-1:0]        x_diff;
        logic [PAIR_COUNT-1:0][DIFF_WIDTH-1:0]        y_diff;
    } limb_stage_t;

    typedef struct packed {
        logic                                         valid;
        logic [LIMB_COUNT-1:0][DIAG_WIDTH-1:0]        diag;
        logic [PAIR_COUNT-1:0][MIX_WIDTH-1:0]         mix;
    } mix_stage_t;

    typedef struct packed {
        logic                                         valid;
        logic [COLUMN_COUNT-1:0][COLUMN_WIDTH-1:0]    column;
    } column_stage_t;

    // Row-major position of limb pair (i, j), i < j
    function automatic int unsigned pair_index(input int unsigned i, input int unsigned j);
        return i * LIMB_COUNT - (i * (i + 1)) / 2 + (j - i - 1);
    endfunction

endpackage

`default_nettype wire

//--- verilog/limb_products.sv
`timescale 1ns/1ps
`default_nettype none

module limb_products (
    input  wire                                     clock,
    input  wire                                     reset,
    input  wire [karatsuba_pkg::OPERAND_WIDTH-1:0]  x,
    input  wire [karatsuba_pkg::OPERAND_WIDTH-1:0]  y,
    input  wire                                     in_valid,
    output karatsuba_pkg::limb_stage_t              stage
);

    logic [karatsuba_pkg::LIMB_COUNT-1:0][karatsuba_pkg::LIMB_WIDTH-1:0] x_limb;
    logic [karatsuba_pkg::LIMB_COUNT-1:0][karatsuba_pkg::LIMB_WIDTH-1:0] y_limb;

    assign x_limb = x;
    assign y_limb = y;

    ////////////////////
    // Stage 1

    always_ff @(posedge clock) begin
        if (reset) begin
            stage.valid <= 1'b0;
        end else begin
            stage.valid <= in_valid;
        end

        for (int i = 0; i < karatsuba_pkg::LIMB_COUNT; i++) begin
            stage.diag[i] <= x_limb[i] * y_limb[i];
        end

        // X takes i - j and Y takes j - i, so their product
        // is the cross term minus both diagonals
        for (int i = 0; i < karatsuba_pkg::LIMB_COUNT; i++) begin
            for (int j = i + 1; j < karatsuba_pkg::LIMB_COUNT; j++) begin
                stage.x_diff[karatsuba_pkg::pair_index(i, j)] <=
                    {1'b0, x_limb[i]} - {1'b0, x_limb[j]};
                stage.y_diff[karatsuba_pkg::pair_index(i, j)] <=
                    {1'b0, y_limb[j]} - {1'b0, y_limb[i]};
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/difference_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module difference_multiplier (
    input  wire                              clock,
    input  wire                              reset,
    input  wire karatsuba_pkg::limb_stage_t  stage_in,
    output karatsuba_pkg::mix_stage_t        stage_out
);

    ////////////////////
    // Stage 2

    always_ff @(posedge clock) begin
        if (reset) begin
            stage_out.valid <= 1'b0;
        end else begin
            stage_out.valid <= stage_in.valid;
        end

        // Diagonals are needed again for the cross terms
        stage_out.diag <= stage_in.diag;

        for (int p = 0; p < karatsuba_pkg::PAIR_COUNT; p++) begin
            stage_out.mix[p] <= $signed(stage_in.x_diff[p]) * $signed(stage_in.y_diff[p]);
        end
    end

    // Upstream strobe must be clean once out of reset
    valid_known_a: assert property (
        @(posedge clock) disable iff (reset)
        !$isunknown(stage_in.valid)
    );

endmodule

`default_nettype wire

//--- verilog/column_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module column_accumulator (
    input  wire                             clock,
    input  wire                             reset,
    input  wire karatsuba_pkg::mix_stage_t  stage_in,
    output karatsuba_pkg::column_stage_t    stage_out
);

    logic signed [karatsuba_pkg::MIX_WIDTH-1:0]  cross_term [karatsuba_pkg::PAIR_COUNT];
    logic [karatsuba_pkg::PAIR_COUNT-1:0]        cross_negative;
    logic [karatsuba_pkg::COLUMN_WIDTH-1:0]      column_sum [karatsuba_pkg::COLUMN_COUNT];

    ////////////////////
    // Cross terms

    // Sum fits the signed width since the true value stays below 2**33
    always_comb begin
        int unsigned pair;
        pair = 0;
        cross_negative = '0;
        for (int i = 0; i < karatsuba_pkg::LIMB_COUNT; i++) begin
            for (int j = i + 1; j < karatsuba_pkg::LIMB_COUNT; j++) begin
                pair = karatsuba_pkg::pair_index(i, j);
                cross_term[pair] = $signed({2'b00, stage_in.diag[i]})
                                 + $signed({2'b00, stage_in.diag[j]})
                                 + $signed(stage_in.mix[pair]);
                cross_negative[pair] = cross_term[pair][karatsuba_pkg::MIX_WIDTH-1];
            end
        end
    end

    ////////////////////
    // Columns by weight

    always_comb begin
        for (int c = 0; c < karatsuba_pkg::COLUMN_COUNT; c++) begin
            column_sum[c] = '0;
        end

        for (int i = 0; i < karatsuba_pkg::LIMB_COUNT; i++) begin
            column_sum[2 * i] = column_sum[2 * i]
                              + karatsuba_pkg::COLUMN_WIDTH'(stage_in.diag[i]);
        end

        // Sign bit is dropped, cross terms are never negative
        for (int i = 0; i < karatsuba_pkg::LIMB_COUNT; i++) begin
            for (int j = i + 1; j < karatsuba_pkg::LIMB_COUNT; j++) begin
                column_sum[i + j] = column_sum[i + j] + karatsuba_pkg::COLUMN_WIDTH'(
                    cross_term[karatsuba_pkg::pair_index(i, j)][karatsuba_pkg::MIX_WIDTH-2:0]);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            stage_out.valid <= 1'b0;
        end else begin
            stage_out.valid <= stage_in.valid;
        end

        for (int c = 0; c < karatsuba_pkg::COLUMN_COUNT; c++) begin
            stage_out.column[c] <= column_sum[c];
        end
    end

    // Fails if limb differences were formed in the wrong order upstream
    cross_sign_a: assert property (
        @(posedge clock) disable iff (reset)
        stage_in.valid |-> cross_negative == '0
    );

endmodule

`default_nettype wire

//--- verilog/product_adder.sv
`timescale 1ns/1ps
`default_nettype none

module product_adder (
    input  wire                                 clock,
    input  wire                                 reset,
    input  wire karatsuba_pkg::column_stage_t   stage_in,
    output logic [karatsuba_pkg::PRODUCT_WIDTH-1:0] product,
    output logic                                out_valid
);

    localparam int ROW_COUNT = karatsuba_pkg::ROW_STRIDE / karatsuba_pkg::LIMB_WIDTH;
    // Top column reaches past the product, its upper bits are zero
    localparam int ROW_WIDTH = (karatsuba_pkg::COLUMN_COUNT - 1) * karatsuba_pkg::LIMB_WIDTH
                             + karatsuba_pkg::COLUMN_WIDTH;

    logic [ROW_WIDTH-1:0] row [ROW_COUNT];
    logic [ROW_WIDTH-1:0] row_sum_01;
    logic [ROW_WIDTH-1:0] row_2;
    logic                 row_valid;
    logic [ROW_WIDTH-1:0] full_sum;

    ////////////////////
    // Stage 4

    // Column 3k + r lands in row r at its own limb weight
    always_comb begin
        for (int r = 0; r < ROW_COUNT; r++) begin
            row[r] = '0;
            for (int k = 0; ROW_COUNT * k + r < karatsuba_pkg::COLUMN_COUNT; k++) begin
                row[r][r * karatsuba_pkg::LIMB_WIDTH + k * karatsuba_pkg::ROW_STRIDE
                       +: karatsuba_pkg::COLUMN_WIDTH] = stage_in.column[ROW_COUNT * k + r];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            row_valid <= 1'b0;
        end else begin
            row_valid <= stage_in.valid;
        end
        row_sum_01 <= row[0] + row[1];
        row_2      <= row[2];
    end

    ////////////////////
    // Stage 5

    assign full_sum = row_sum_01 + row_2;

    always_ff @(posedge clock) begin
        if (reset) begin
            product   <= '0;
            out_valid <= 1'b0;
        end else begin
            product   <= full_sum[karatsuba_pkg::PRODUCT_WIDTH-1:0];
            out_valid <= row_valid;
        end
    end

    // Anything above the product width means a bad column upstream
    no_carry_out_a: assert property (
        @(posedge clock) disable iff (reset)
        row_valid |-> full_sum[ROW_WIDTH-1:karatsuba_pkg::PRODUCT_WIDTH] == '0
    );

endmodule

`default_nettype wire

//--- verilog/karatsuba_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module karatsuba_multiplier (
    input  wire                                     clock,
    input  wire                                     reset,
    input  wire [karatsuba_pkg::OPERAND_WIDTH-1:0]  x,
    input  wire [karatsuba_pkg::OPERAND_WIDTH-1:0]  y,
    input  wire                                     in_valid,
    output wire [karatsuba_pkg::PRODUCT_WIDTH-1:0]  product,
    output wire                                     out_valid
);

    wire karatsuba_pkg::limb_stage_t   limb_stage;
    wire karatsuba_pkg::mix_stage_t    mix_stage;
    wire karatsuba_pkg::column_stage_t column_stage;

    limb_products u_limb_products (
        .clock    (clock),
        .reset    (reset),
        .x        (x),
        .y        (y),
        .in_valid (in_valid),
        .stage    (limb_stage)
    );

    difference_multiplier u_difference_multiplier (
        .clock     (clock),
        .reset     (reset),
        .stage_in  (limb_stage),
        .stage_out (mix_stage)
    );

    column_accumulator u_column_accumulator (
        .clock     (clock),
        .reset     (reset),
        .stage_in  (mix_stage),
        .stage_out (column_stage)
    );

    // Two cycles, five in total
    product_adder u_product_adder (
        .clock     (clock),
        .reset     (reset),
        .stage_in  (column_stage),
        .product   (product),
        .out_valid (out_valid)
    );

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    // 40 ns period
    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Two rising edges with reset high, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- tests/tb_karatsuba_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module tb_karatsuba_multiplier;

    localparam int OPERAND_WIDTH = karatsuba_pkg::OPERAND_WIDTH;
    localparam int PRODUCT_WIDTH = karatsuba_pkg::PRODUCT_WIDTH;
    localparam int LIMB_WIDTH    = karatsuba_pkg::LIMB_WIDTH;
    localparam int LATENCY       = 5;
    localparam int DRAIN_LIMIT   = LATENCY + 2;
    localparam int BURST_PAIRS   = 200;
    localparam int GAPPED_PAIRS  = 100;
    // About four times the length of all tests
    localparam int CYCLE_LIMIT   = 2000;

    wire                        clock;
    wire                        power_on_reset;
    wire                        reset;
    logic                       extra_reset;
    logic [OPERAND_WIDTH-1:0]   x;
    logic [OPERAND_WIDTH-1:0]   y;
    logic                       in_valid;
    wire  [PRODUCT_WIDTH-1:0]   product;
    wire                        out_valid;

    logic [PRODUCT_WIDTH-1:0]   expect_queue [$];
    int                         issue_queue [$];
    int                         edge_count = 0;
    int                         error_count = 0;
    int                         errors_at_start = 0;
    int                         tests_passed = 0;
    int                         tests_failed = 0;
    string                      test_name = "startup";
    logic [31:0]                lfsr_state = 32'hb0b7;

    assign reset = power_on_reset | extra_reset;

    tb_clock_gen clock_gen (
        .clock (clock),
        .reset (power_on_reset)
    );

    karatsuba_multiplier dut (
        .clock     (clock),
        .reset     (reset),
        .x         (x),
        .y         (y),
        .in_valid  (in_valid),
        .product   (product),
        .out_valid (out_valid)
    );

    ////////////////////
    // Reference and random source

    function automatic logic [PRODUCT_WIDTH-1:0] reference_product(
        input logic [OPERAND_WIDTH-1:0] a,
        input logic [OPERAND_WIDTH-1:0] b
    );
        logic [PRODUCT_WIDTH-1:0] wide_a;
        logic [PRODUCT_WIDTH-1:0] wide_b;
        wide_a = PRODUCT_WIDTH'(a);
        wide_b = PRODUCT_WIDTH'(b);
        return wide_a * wide_b;
    endfunction

    // Taps 32, 22, 2, 1
    function automatic logic next_random_bit();
        logic feedback;
        feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [OPERAND_WIDTH-1:0] random_operand();
        logic [OPERAND_WIDTH-1:0] value;
        for (int b = 0; b < OPERAND_WIDTH; b++) begin
            value[b] = next_random_bit();
        end
        return value;
    endfunction

    ////////////////////
    // Checking

    task automatic check_value(
        input string                    name,
        input logic [PRODUCT_WIDTH-1:0] expected,
        input logic [PRODUCT_WIDTH-1:0] actual
    );
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            error_count++;
        end
    endtask

    // Inputs are stable here, half a period after they were driven
    always @(posedge clock) begin
        edge_count <= edge_count + 1;
        if (reset) begin
            expect_queue.delete();
            issue_queue.delete();
        end else if (in_valid) begin
            expect_queue.push_back(reference_product(x, y));
            issue_queue.push_back(edge_count);
        end
    end

    always @(negedge clock) begin : compare_outputs
        logic [PRODUCT_WIDTH-1:0] expected;
        int                       issued;
        if (out_valid === 1'b1) begin
            if (expect_queue.size() == 0) begin
                $display("ERROR in %s: out_valid high at cycle %0d with no product pending",
                         test_name, edge_count);
                error_count++;
            end else begin
                expected = expect_queue.pop_front();
                issued   = issue_queue.pop_front();
                check_value(test_name, expected, product);
                check_value({test_name, " latency"}, LATENCY, edge_count - issued);
            end
        end
    end

    always @(posedge clock) begin
        if (edge_count >= CYCLE_LIMIT) begin
            $display("Timeout: run stopped after %0d cycles in %s", edge_count, test_name);
            $display("=== FAIL ===");
            $finish;
        end
    end

    ////////////////////
    // Stimulus

    task automatic present_pair(input logic [OPERAND_WIDTH-1:0] a,
                                input logic [OPERAND_WIDTH-1:0] b);
        @(negedge clock);
        x        = a;
        y        = b;
        in_valid = 1'b1;
    endtask

    task automatic go_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            in_valid = 1'b0;
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    task automatic finish_test();
        int waited;
        waited = 0;
        go_idle(1);
        while (expect_queue.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        go_idle(2);
        if (error_count == errors_at_start) begin
            $display("test %s: passed", test_name);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", test_name, error_count - errors_at_start);
            tests_failed++;
        end
    endtask

    task automatic run_single(input string name,
                              input logic [OPERAND_WIDTH-1:0] a,
                              input logic [OPERAND_WIDTH-1:0] b);
        start_test(name);
        present_pair(a, b);
        finish_test();
    endtask

    initial begin
        logic [OPERAND_WIDTH-1:0] a;
        logic [OPERAND_WIDTH-1:0] b;
        logic [1:0]               gap;

        x           = '0;
        y           = '0;
        in_valid    = 1'b0;
        extra_reset = 1'b0;

        while (reset !== 1'b0) begin
            @(negedge clock);
        end
        @(negedge clock);
        start_test("reset_state");
        check_value("reset_state out_valid", '0, out_valid);
        check_value("reset_state product", '0, product);
        finish_test();

        // Directed corner cases
        run_single("zero_times_random", '0, random_operand());
        run_single("all_ones", '1, '1);
        run_single("one_times_random", OPERAND_WIDTH'(1), random_operand());
        for (int i = 0; i < karatsuba_pkg::LIMB_COUNT; i++) begin
            a[i*LIMB_WIDTH +: LIMB_WIDTH] = 16'h00a5 + 16'h0f00 * i + i;
            b[i*LIMB_WIDTH +: LIMB_WIDTH] = 16'hff5a - 16'h0e00 * i;
        end
        run_single("negative_differences", a, b);
        a = '0;
        b = '0;
        a[5*LIMB_WIDTH +: LIMB_WIDTH]  = 16'hbeef;
        b[11*LIMB_WIDTH +: LIMB_WIDTH] = 16'h8001;
        run_single("single_limb", a, b);

        start_test("random_burst");
        for (int n = 0; n < BURST_PAIRS; n++) begin
            a = random_operand();
            b = random_operand();
            present_pair(a, b);
        end
        finish_test();

        start_test("random_gaps");
        for (int n = 0; n < GAPPED_PAIRS; n++) begin
            gap[0] = next_random_bit();
            gap[1] = next_random_bit();
            go_idle(gap);
            a = random_operand();
            b = random_operand();
            present_pair(a, b);
        end
        finish_test();

        // Reset drops the products in flight
        start_test("reset_in_flight");
        for (int n = 0; n < 3; n++) begin
            a = random_operand();
            b = random_operand();
            present_pair(a, b);
        end
        @(negedge clock);
        in_valid    = 1'b0;
        extra_reset = 1'b1;
        @(negedge clock);
        extra_reset = 1'b0;
        go_idle(8);
        a = random_operand();
        b = random_operand();
        present_pair(a, b);
        finish_test();

        if (expect_queue.size() != 0) begin
            $display("ERROR: %0d products were never delivered", expect_queue.size());
            error_count++;
        end
        $display("%0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
verilog/karatsuba_pkg.sv
verilog/limb_products.sv
verilog/difference_multiplier.sv
verilog/column_accumulator.sv
verilog/product_adder.sv
verilog/karatsuba_multiplier.sv
tests/tb_clock_gen.sv
tests/tb_karatsuba_multiplier.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_karatsuba_multiplier \
    -f build.f -o tb_karatsuba_multiplier
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_karatsuba_multiplier > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    exit 1
fi
if ! grep -q "=== PASS ===" "$LOG"; then
    echo "No pass line in $LOG"
    exit 1
fi
exit 0
